//--- list.f
source/sd_probe_pkg.sv
source/boot_pacer.sv
source/sd_status_reader.sv
source/report_sequencer.sv
source/sd_probe_top.sv
verif/sd_slave_bfm.sv
verif/sd_probe_tb.sv

//--- verif/sd_probe_tb.sv
// sd_probe_tb testbench with clock, reset, random runs, reference model and compare tasks

`timescale 1ns/1ns

module sd_probe_tb import sd_probe_pkg::*; ();

    localparam int startup_delay  = 20;
    localparam int char_gap       = 7;
    localparam int heartbeat_bits = 6;
    localparam int num_runs       = 12;
    localparam int wait_limit     = 200;
    localparam int quiet_cycles   = 200;

    logic        CLOCK_50;
    logic        KEY0;
    logic        ledr0;
    logic        sd_chipselect;
    logic        sd_read;
    logic [31:0] sd_readdata;
    logic        sd_waitrequest;
    logic [31:0] uart_data;
    logic        uart_write;

    // per run setup
    int unsigned stretch_tb;
    logic        card_tb;
    logic [31:0] fill_tb;

    // observation state, cyc is the cycle just sampled
    int          cyc;
    bit          acc_seen;
    int          acc_cyc;
    int          acc_count;
    logic        wr_seen;
    uart_char_t  wr_char;
    logic [31:0] wr_word;
    int unsigned seed_ret;

    sd_probe_top #(
        .startup_delay  (startup_delay),
        .char_gap       (char_gap),
        .heartbeat_bits (heartbeat_bits)
    ) sd_probe_top_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ledr0          (ledr0),
        .sd_chipselect  (sd_chipselect),
        .sd_read        (sd_read),
        .sd_readdata    (sd_readdata),
        .sd_waitrequest (sd_waitrequest),
        .uart_data      (uart_data),
        .uart_write     (uart_write)
    );

    sd_slave_bfm sd_slave_bfm_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .sd_chipselect  (sd_chipselect),
        .sd_read        (sd_read),
        .sd_readdata    (sd_readdata),
        .sd_waitrequest (sd_waitrequest),
        .stretch        (stretch_tb),
        .card_present   (card_tb),
        .fill           (fill_tb)
    );

    // 40 ns period
    always #20 CLOCK_50 = ~CLOCK_50;

    // ==================================================
    // compare tasks
    // ==================================================

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            abort_run();
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_char(input string name, input uart_char_t got,
                              input uart_char_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input sd_status_t got,
                                input sd_status_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            abort_run();
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================

    // OK with a card, NO without
    function automatic logic [7:0] report_char(input logic card, input bit second);
        if (card) begin
            return second ? char_k : char_o;
        end
        return second ? char_o : char_n;
    endfunction

    // ==================================================
    // cycle monitor
    // ==================================================

    // one clock, values sampled as they stood before the edge
    task automatic tick();
        logic       exp_read;
        sd_status_t seen;
        sd_status_t exp_status;
        @(posedge CLOCK_50);
        cyc = cyc + 1;
        // heartbeat counts from reset release
        check_bit("ledr0", ledr0, cyc[heartbeat_bits-1]);
        // request from cycle 1 up to and including acceptance
        exp_read = (cyc >= 1) && !acc_seen;
        check_bit("sd_read", sd_read, exp_read);
        check_bit("sd_chipselect", sd_chipselect, exp_read);
        // slave drops waitrequest once, in its acceptance cycle
        if (!sd_waitrequest && !acc_seen && (cyc >= 1)) begin
            acc_cyc          = cyc;
            acc_seen         = 1'b1;
            seen.valid       = sd_chipselect && sd_read;
            seen.card_present = sd_readdata[0];
            exp_status.valid = 1'b1;
            exp_status.card_present = card_tb;
            check_status("sd status at acceptance", seen, exp_status);
            check_value("sd acceptance cycle", acc_cyc, stretch_tb + 1);
        end
        if (sd_read && !sd_waitrequest) begin
            acc_count = acc_count + 1;
        end
        wr_seen      = uart_write;
        wr_char.write = uart_write;
        wr_char.data = uart_data[7:0];
        wr_word      = uart_data;
    endtask

    // next uart write, with timeout
    task automatic wait_char(input string what, input logic [7:0] exp_data,
                             input bit need_accept, output int at_cyc);
        int         n;
        uart_char_t exp;
        n = 0;
        wr_seen = 1'b0;
        while (!wr_seen && n < wait_limit) begin
            tick();
            n = n + 1;
        end
        if (!wr_seen) begin
            $display("timeout: character %s never came on uart_write", what);
            abort_run();
        end
        if (need_accept && !acc_seen) begin
            $display("character %s came before the sd status read was accepted", what);
            abort_run();
        end
        exp.write = 1'b1;
        exp.data  = exp_data;
        check_char("uart_data char", wr_char, exp);
        check_value("uart_data[31:8]", {8'h00, wr_word[31:8]}, 32'h0);
        at_cyc = cyc;
    endtask

    // ==================================================
    // runs
    // ==================================================

    // config and KEY0 change on the same edge, low for 4 cycles
    task automatic apply_reset(input int unsigned stretch, input logic card,
                               input logic [31:0] fill);
        @(posedge CLOCK_50);
        KEY0       <= 1'b0;
        stretch_tb <= stretch;
        card_tb    <= card;
        fill_tb    <= fill;
        repeat (4) @(posedge CLOCK_50);
        KEY0      <= 1'b1;
        cyc       = -1;
        acc_seen  = 1'b0;
        acc_cyc   = 0;
        acc_count = 0;
    endtask

    task automatic run_once(input int idx);
        int unsigned stretch;
        logic        card;
        logic [7:0]  first_c;
        logic [7:0]  second_c;
        int          s_at;
        int          d_at;
        int          f_at;
        int          g_at;
        int          both_at;
        stretch  = $urandom % 41;
        card     = $urandom % 2;
        first_c  = report_char(card, 1'b0);
        second_c = report_char(card, 1'b1);
        $display("run %0d: card %0d, waitrequest stretch %0d", idx, card, stretch);
        apply_reset(stretch, card, $urandom);

        wait_char("S", char_s, 1'b0, s_at);
        check_value("S cycle", s_at, startup_delay + 1);
        wait_char("D", char_d, 1'b0, d_at);
        check_value("D cycle", d_at, s_at + char_gap + 1);

        // banner_done from the D cycle, status valid after acceptance
        wait_char($sformatf("%c (first report)", first_c), first_c, 1'b1, f_at);
        both_at = (d_at > acc_cyc + 1) ? d_at : acc_cyc + 1;
        check_value("first report cycle", f_at, both_at + 1);
        wait_char($sformatf("%c (second report)", second_c), second_c, 1'b1, g_at);
        check_value("second report cycle", g_at, f_at + 1);

        // silent after the report
        for (int n = 0; n < quiet_cycles; n++) begin
            tick();
            if (wr_seen) begin
                $display("uart_write strobed %0d cycles after the report", n + 1);
                abort_run();
            end
        end
        check_value("accepted sd reads", acc_count, 1);
    endtask

    initial begin
        CLOCK_50   = 1'b0;
        KEY0       = 1'b0;
        stretch_tb = 0;
        card_tb    = 1'b0;
        fill_tb    = 32'd0;
        cyc        = -1;
        acc_seen   = 1'b0;
        acc_cyc    = 0;
        acc_count  = 0;
        wr_seen    = 1'b0;
        wr_char    = '0;
        wr_word    = 32'd0;
        seed_ret   = $urandom(63301);
        for (int r = 0; r < num_runs; r++) begin
            run_once(r);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verif/sd_slave_bfm.sv
// sd_slave_bfm module modelling the sd controller status slave with waitrequest stretch

`timescale 1ns/1ns

module sd_slave_bfm (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        sd_chipselect,
    input  logic        sd_read,
    output logic [31:0] sd_readdata,
    output logic        sd_waitrequest,
    // run setup from the testbench
    input  int unsigned stretch,
    input  logic        card_present,
    input  logic [31:0] fill
);

    int unsigned stall_cnt;

    // defined levels before the first edge
    initial begin
        sd_waitrequest = 1'b1;
        sd_readdata    = 32'd0;
        stall_cnt      = 0;
    end

    // ==================================================
    // status slave
    // ==================================================

    // stall for stretch request cycles, then accept
    // bit 0 is inverted while stalled so an early sample shows up
    always @(posedge CLOCK_50) begin
        if (!KEY0) begin
            stall_cnt      <= 0;
            sd_waitrequest <= (stretch != 0);
            sd_readdata    <= {fill[31:1], (stretch == 0) ? card_present : ~card_present};
        end else if (sd_read && sd_chipselect && sd_waitrequest) begin
            stall_cnt <= stall_cnt + 1;
            if (stall_cnt + 1 >= stretch) begin
                // accept in the next cycle
                sd_waitrequest <= 1'b0;
                sd_readdata    <= {fill[31:1], card_present};
            end
        end else if (sd_read && sd_chipselect) begin
            // accepted this cycle, back to stalling
            sd_waitrequest <= 1'b1;
            sd_readdata    <= {fill[31:1], ~card_present};
        end
    end

endmodule

//--- source/sd_probe_top.sv
// sd_probe_top module connecting pacer, status reader and sequencer to board ports

`timescale 1ns/1ns

module sd_probe_top import sd_probe_pkg::*; #(
    parameter logic [23:0] startup_delay  = 24'd5_000_000,
    parameter logic [23:0] char_gap       = 24'd100_000,
    parameter int          heartbeat_bits = 24
) (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    output logic        ledr0,

    // sd controller status slave
    output logic        sd_chipselect,
    output logic        sd_read,
    input  logic [31:0] sd_readdata,
    input  logic        sd_waitrequest,

    // jtag uart write port
    output logic [31:0] uart_data,
    output logic        uart_write
);

    // pacer to sequencer
    uart_char_t banner;
    logic       banner_done;

    // reader to sequencer
    sd_status_t status;

    // ==================================================
    // banner and heartbeat
    // ==================================================
    boot_pacer #(
        .startup_delay  (startup_delay),
        .char_gap       (char_gap),
        .heartbeat_bits (heartbeat_bits)
    ) boot_pacer_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .ledr0       (ledr0),
        .banner      (banner),
        .banner_done (banner_done)
    );

    // ==================================================
    // sd status read
    // ==================================================
    sd_status_reader sd_status_reader_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .sd_chipselect  (sd_chipselect),
        .sd_read        (sd_read),
        .sd_readdata    (sd_readdata),
        .sd_waitrequest (sd_waitrequest),
        .status         (status)
    );

    // ==================================================
    // uart report
    // ==================================================
    report_sequencer report_sequencer_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .banner      (banner),
        .banner_done (banner_done),
        .status      (status),
        .uart_data   (uart_data),
        .uart_write  (uart_write)
    );

endmodule

//--- source/report_sequencer.sv
// report_sequencer module merging banner chars and sd status into uart writes

`timescale 1ns/1ns

module report_sequencer import sd_probe_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  uart_char_t  banner,
    input  logic        banner_done,
    input  sd_status_t  status,
    output logic [31:0] uart_data,
    output logic        uart_write
);

    report_state_e state;
    logic          both_ready;
    logic [7:0]    first_char;
    logic [7:0]    second_char;
    logic [7:0]    next_char;
    logic [7:0]    char_q;

    // ==================================================
    // report chars
    // ==================================================

    // OK with a card, NO without
    assign first_char  = status.card_present ? char_o : char_n;
    assign second_char = status.card_present ? char_k : char_o;

    assign both_ready = banner_done && status.valid;

    // ==================================================
    // state machine
    // ==================================================

    // state names the char currently sitting on the uart port
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= wait_both;
            uart_write <= 1'b0;
        end else begin
            uart_write <= 1'b0;
            case (state)
                wait_both: begin
                    // banner passes through one register stage
                    uart_write <= banner.write;
                    if (both_ready) begin
                        uart_write <= 1'b1;
                        state      <= send_first;
                    end
                end
                send_first: begin
                    // second char right behind the first
                    uart_write <= 1'b1;
                    state      <= send_second;
                end
                send_second: begin
                    state <= done;
                end
                // silent until the next reset
                done: begin
                    state <= done;
                end
                default: begin
                    state <= wait_both;
                end
            endcase
        end
    end

    // ==================================================
    // uart data
    // ==================================================

    // char picked to match the write strobe above
    always_comb begin
        next_char = char_q;
        case (state)
            wait_both: begin
                if (both_ready) begin
                    next_char = first_char;
                end else if (banner.write) begin
                    next_char = banner.data;
                end
            end
            send_first: begin
                next_char = second_char;
            end
            default: begin
                next_char = char_q;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        char_q <= next_char;
    end

    // uart takes the char in the low byte
    assign uart_data = {24'd0, char_q};

    // ==================================================
    // checks
    // ==================================================

    // done means silent
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (state == done) |-> !uart_write);

    // every banner strobe reaches the uart one cycle later
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        banner.write |=> uart_write);

endmodule

//--- source/sd_status_reader.sv
// sd_status_reader module issuing one avalon status read and latching card present

`timescale 1ns/1ns

module sd_status_reader import sd_probe_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    output logic        sd_chipselect,
    output logic        sd_read,
    input  logic [31:0] sd_readdata,
    input  logic        sd_waitrequest,
    output sd_status_t  status
);

    // read phases
    typedef enum logic [1:0] {
        rd_idle    = 2'd0,
        rd_request = 2'd1,
        rd_done    = 2'd2
    } reader_phase_e;

    reader_phase_e rd_phase;
    logic          accept;
    sd_status_t    status_q;

    // ==================================================
    // avalon read request
    // ==================================================

    // request held while the slave stretches waitrequest
    assign sd_read       = (rd_phase == rd_request);
    assign sd_chipselect = (rd_phase == rd_request);

    // zero latency slave, readdata valid in the accept cycle
    assign accept = sd_read && !sd_waitrequest;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_phase <= rd_idle;
        end else begin
            case (rd_phase)
                // first edge after reset raises the request
                rd_idle: begin
                    rd_phase <= rd_request;
                end
                rd_request: begin
                    if (accept) begin
                        rd_phase <= rd_done;
                    end
                end
                // one read per reset
                rd_done: begin
                    rd_phase <= rd_done;
                end
                default: begin
                    rd_phase <= rd_idle;
                end
            endcase
        end
    end

    // ==================================================
    // latched result
    // ==================================================

    // sample bit 0 at acceptance
    // valid shows up one cycle later and stays
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            status_q.valid        <= 1'b0;
            status_q.card_present <= 1'b0;
        end else if (accept) begin
            status_q.valid        <= 1'b1;
            status_q.card_present <= sd_readdata[0];
        end
    end

    assign status = status_q;

    // ==================================================
    // bus checks
    // ==================================================

    // avalon master may not drop a stalled read
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (sd_read && sd_waitrequest) |=> sd_read);

    // chipselect and read travel together
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_chipselect == sd_read);

endmodule

//--- source/boot_pacer.sv
// boot_pacer module with heartbeat counter, startup delay and banner timing

`timescale 1ns/1ns

module boot_pacer import sd_probe_pkg::*; #(
    parameter logic [23:0] startup_delay  = 24'd5_000_000,
    parameter logic [23:0] char_gap       = 24'd100_000,
    parameter int          heartbeat_bits = 24
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    output logic       ledr0,
    output uart_char_t banner,
    output logic       banner_done
);

    // pacing phases
    typedef enum logic [1:0] {
        phase_startup  = 2'd0,
        phase_gap      = 2'd1,
        phase_finished = 2'd2
    } pacer_phase_e;

    logic [heartbeat_bits-1:0] beat_cnt;
    logic [23:0]               delay_cnt;
    pacer_phase_e              phase;
    logic                      s_hit;
    logic                      d_hit;

    // ==================================================
    // heartbeat
    // ==================================================

    // free running, top bit drives the led
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign ledr0 = beat_cnt[heartbeat_bits-1];

    // ==================================================
    // banner delays
    // ==================================================

    // counter reaches startup_delay in cycle startup_delay
    assign s_hit = (phase == phase_startup) && (delay_cnt == startup_delay);
    // restarts at zero after S, so D lands char_gap + 1 later
    assign d_hit = (phase == phase_gap) && (delay_cnt == char_gap);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            phase     <= phase_startup;
            delay_cnt <= '0;
        end else begin
            if (s_hit) begin
                phase     <= phase_gap;
                delay_cnt <= '0;
            end else if (d_hit) begin
                // counter parks here for good
                phase     <= phase_finished;
                delay_cnt <= '0;
            end else if (phase != phase_finished) begin
                delay_cnt <= delay_cnt + 1'b1;
            end
        end
    end

    // strobe decoded straight from phase and count
    assign banner.write = s_hit || d_hit;
    assign banner.data  = (phase == phase_gap) ? char_d : char_s;

    // level from the cycle after D
    assign banner_done = (phase == phase_finished);

    // no banner char once the banner is reported finished
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(banner.write && banner_done));

endmodule

//--- source/sd_probe_pkg.sv
// shared report types, sequencer state enum and ascii character constants

package sd_probe_pkg;

    // ==================================================
    // character strobe towards the jtag uart
    // ==================================================

    // one character per cycle when write is high
    typedef struct packed {
        logic       write;
        logic [7:0] data;
    } uart_char_t;

    // ==================================================
    // latched sd status
    // ==================================================

    // valid rises once the single status read is accepted
    // card_present is bit 0 of the status register
    typedef struct packed {
        logic valid;
        logic card_present;
    } sd_status_t;

    // ==================================================
    // report sequencer states
    // ==================================================

    // wait_both waits for banner and status
    // send_first and send_second name the report char on the uart port
    typedef enum logic [1:0] {
        wait_both   = 2'd0,
        send_first  = 2'd1,
        send_second = 2'd2,
        done        = 2'd3
    } report_state_e;

    // ==================================================
    // ascii codes
    // ==================================================

    // banner
    localparam logic [7:0] char_s = 8'h53;
    localparam logic [7:0] char_d = 8'h44;

    // card present
    localparam logic [7:0] char_o = 8'h4f;
    localparam logic [7:0] char_k = 8'h4b;

    // no card, sent as N then O
    localparam logic [7:0] char_n = 8'h4e;

endpackage
